//--- Makefile
# Verilator build and run for the fetch unit testbench

VERILATOR ?= verilator
TOP       ?= tbFetchUnit
FILELIST  ?= all.f
OBJDIR    ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --assert -j 0
FAILMSG   ?= ** FAIL **
PASSMSG   ?= ** PASS **

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJDIR)

run: build
	-./$(OBJDIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -qF '$(FAILMSG)' $(LOG); then echo "simulation failed, see $(LOG)"; exit 1; fi
	@if ! grep -qF '$(PASSMSG)' $(LOG); then echo "simulation ended early, see $(LOG)"; exit 1; fi

lint:
	$(VERILATOR) --lint-only --timing --assert --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJDIR) $(LOG)

//--- all.f
logic/fetchPkg.sv
logic/fetchIfs.sv
logic/fetchStage.sv
logic/instrCache.sv
logic/instrBackingMem.sv
logic/fetchUnit.sv
verif/tbClockGen.sv
verif/fetchUnit_properties.sv
verif/tbFetchUnit.sv

//--- logic/fetchIfs.sv
`timescale 1ns/1ps
//************************************************************
// fetch internal links
// instruction request (stage to cache) and line fill
// (cache to backing memory), both four-phase req/ack
//************************************************************

// fetch stage <-> instruction cache
interface instrReqIf;
    logic          req;    // held until ack seen
    fetchPkg::word addr;   // byte address, stable while req high
    logic          ack;    // data valid while high
    fetchPkg::word data;
    logic          err;    // addr beyond program memory

    modport requester (
        output req, addr,
        input  ack, data, err
    );

    modport responder (
        input  req, addr,
        output ack, data, err
    );
endinterface

// instruction cache <-> backing memory
interface lineFillIf;
    logic          req;
    fetchPkg::word lineAddr;   // line-aligned byte address
    logic          ack;
    fetchPkg::line lineData;   // whole line, valid while ack high

    modport requester (
        output req, lineAddr,
        input  ack, lineData
    );

    modport responder (
        input  req, lineAddr,
        output ack, lineData
    );
endinterface

//--- logic/fetchPkg.sv
//************************************************************
// fetch subsystem shared types
// word type, cache line geometry and the cache FSM states
//************************************************************
package fetchPkg;

    // 16-bit instruction / address value, fixed by the ISA
    typedef logic [15:0] word;

    localparam int lineWords = 4;    // words per cache line
    localparam int memWords  = 256;  // program memory depth in words

    // one cache line, word 0 in the low bits
    typedef word [lineWords-1:0] line;

    // instruction cache controller states
    typedef enum logic [1:0] {
        idle,       // waiting for a fetch request
        lookup,     // tag / valid compare
        fill,       // line fill outstanding on the backing memory
        respond     // ack held until fetch drops req
    } cacheState;

endpackage

//--- logic/fetchStage.sv
`timescale 1ns/1ps
//************************************************************
// instruction fetch stage
// PC register, PC+2, redirect select, pending-redirect
// tracking and requester side of the instruction handshake
//************************************************************
module fetchStage (
    input  logic          clk,
    input  logic          rstN,
    input  logic          writePc1,     // low on load-use hazard
    input  logic          writePc2,     // low on data memory stall
    input  logic          branchTake,
    input  logic          jump,
    input  fetchPkg::word brAddr,
    input  fetchPkg::word jumpAddr,
    output fetchPkg::word pcOut,        // address being fetched
    output fetchPkg::word nxtPc,        // pcOut + 2
    output fetchPkg::word instr,
    output logic          validIns,     // one cycle per issued instruction
    output logic          err,
    instrReqIf.requester  mem
);

    fetchPkg::word pcQ;
    fetchPkg::word pcIn;        // next PC when the PC is written
    fetchPkg::word liveTarget;  // redirect target this cycle
    fetchPkg::word pendAddrQ;   // latched redirect target
    fetchPkg::word instrQ;      // last delivered instruction
    logic          reqQ;
    logic          pendQ;       // redirect seen before done
    logic          brOrJ;
    logic          done;        // first cycle ack seen with req high
    logic          pcWrite;
    logic          ofErr;

    // incrementer, carry out flags wrap past 16'hFFFE
    assign {ofErr, nxtPc} = {1'b0, pcQ} + 17'd2;

    assign brOrJ      = branchTake | jump;
    assign liveTarget = jump ? jumpAddr : brAddr;  // jump wins

    // req falls in the cycle after done, so done lasts one cycle
    assign done    = reqQ & mem.ack;
    assign pcWrite = done & writePc1 & writePc2;

    // an older latched redirect beats a live one
    always_comb begin
        if (pendQ) begin
            pcIn = pendAddrQ;
        end else if (brOrJ) begin
            pcIn = liveTarget;
        end else begin
            pcIn = nxtPc;
        end
    end

    // four-phase requester
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            reqQ <= 1'b0;
        end else if (reqQ) begin
            if (mem.ack) begin
                reqQ <= 1'b0;    // phase 3 drop req
            end
        end else if (!mem.ack) begin
            reqQ <= 1'b1;        // previous ack gone, start next fetch
        end
    end

    // PC only moves on done with both write enables high
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            pcQ <= '0;
        end else if (pcWrite) begin
            pcQ <= pcIn;
        end
    end

    // pending flag set by a redirect that the PC could not take yet,
    // held across stalled dones until the PC finally loads the target
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            pendQ <= 1'b0;
        end else begin
            pendQ <= (pendQ | brOrJ) & ~pcWrite;
        end
    end

    // first redirect target is kept while pending
    always_ff @(posedge clk) begin
        if (brOrJ && !pendQ) begin
            pendAddrQ <= liveTarget;
        end
        if (done) begin
            instrQ <= mem.data;   // kept across stalls
        end
    end

    assign mem.req  = reqQ;
    assign mem.addr = pcQ;      // stable while req high

    assign pcOut    = pcQ;
    assign instr    = done ? mem.data : instrQ;
    assign validIns = done & ~pendQ;    // stale fetch dropped here
    assign err      = ofErr | mem.err;

endmodule

//--- logic/fetchUnit.sv
`timescale 1ns/1ps
//************************************************************
// instruction fetch unit top level
// fetch stage, instruction cache and backing memory
//************************************************************
module fetchUnit #(
    parameter int numLines    = 8,  // cache lines
    parameter int fillLatency = 4   // backing memory wait
) (
    input  logic          clk,
    input  logic          rstN,
    input  logic          writePc1,
    input  logic          writePc2,
    input  logic          branchTake,
    input  logic          jump,
    input  fetchPkg::word brAddr,
    input  fetchPkg::word jumpAddr,
    output fetchPkg::word pcOut,
    output fetchPkg::word nxtPc,
    output fetchPkg::word instr,
    output logic          validIns,
    output logic          err
);

    instrReqIf reqBus ();   // stage -> cache
    lineFillIf fillBus ();  // cache -> memory

    fetchStage iStage (
        .clk        (clk),
        .rstN       (rstN),
        .writePc1   (writePc1),
        .writePc2   (writePc2),
        .branchTake (branchTake),
        .jump       (jump),
        .brAddr     (brAddr),
        .jumpAddr   (jumpAddr),
        .pcOut      (pcOut),
        .nxtPc      (nxtPc),
        .instr      (instr),
        .validIns   (validIns),
        .err        (err),
        .mem        (reqBus.requester)
    );

    instrCache #(.numLines(numLines)) iCache (
        .clk  (clk),
        .rstN (rstN),
        .cpu  (reqBus.responder),
        .fill (fillBus.requester)
    );

    instrBackingMem #(.fillLatency(fillLatency)) iBackMem (
        .clk  (clk),
        .rstN (rstN),
        .fill (fillBus.responder)
    );

endmodule

//--- logic/instrBackingMem.sv
`timescale 1ns/1ps
//************************************************************
// program backing memory
// image from program.hex, one line per fill after a fixed wait
//************************************************************
module instrBackingMem #(
    parameter int fillLatency = 4
) (
    input  logic         clk,
    input  logic         rstN,
    lineFillIf.responder fill
);

    localparam int addrBits = $clog2(fetchPkg::memWords);
    localparam int cntBits  = $clog2(fillLatency + 1);

    fetchPkg::word       memArr [fetchPkg::memWords];
    fetchPkg::line       lineQ;
    logic [cntBits-1:0]  cnt;        // wait cycles so far
    logic [addrBits-1:0] baseIdx;    // word index of line start
    logic                ackQ;
    logic                lastWait;

    initial begin
        $readmemh("program.hex", memArr);
    end

    assign baseIdx  = fill.lineAddr[addrBits:1];
    assign lastWait = cnt == cntBits'(fillLatency - 1);

    // wait counter and ack
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            cnt  <= '0;
            ackQ <= 1'b0;
        end else if (fill.req && !ackQ) begin
            if (lastWait) begin
                cnt  <= '0;
                ackQ <= 1'b1;   // ack fillLatency cycles after req
            end else begin
                cnt <= cnt + 1'b1;
            end
        end else if (!fill.req && ackQ) begin
            ackQ <= 1'b0;       // req gone, release
        end
    end

    // line captured together with ack rise
    always_ff @(posedge clk) begin
        if (fill.req && !ackQ && lastWait) begin
            for (int i = 0; i < fetchPkg::lineWords; i++) begin
                lineQ[i] <= memArr[baseIdx + addrBits'(i)];
            end
        end
    end

    assign fill.ack      = ackQ;
    assign fill.lineData = lineQ;

endmodule

//--- logic/instrCache.sv
`timescale 1ns/1ps
//************************************************************
// direct-mapped read-only instruction cache
// tag/valid lookup, whole-line fill from the backing memory
//************************************************************
module instrCache #(
    parameter int numLines = 8
) (
    input  logic         clk,
    input  logic         rstN,
    instrReqIf.responder cpu,
    lineFillIf.requester fill
);

    // byte address = {tag, index, offset, 1'b0}
    localparam int offBits = $clog2(fetchPkg::lineWords);
    localparam int idxBits = $clog2(numLines);
    localparam int tagBits = 16 - 1 - offBits - idxBits;
    localparam fetchPkg::word memLimit = fetchPkg::word'(fetchPkg::memWords * 2);

    fetchPkg::cacheState state;
    fetchPkg::line       dataArr [numLines];
    logic [tagBits-1:0]  tagArr  [numLines];
    logic [numLines-1:0] validArr;

    logic [offBits-1:0]  off;
    logic [idxBits-1:0]  idx;
    logic [tagBits-1:0]  tag;
    logic                hit;
    logic                addrErr;
    logic                ackQ;
    logic                fillReqQ;
    fetchPkg::word       dataQ;

    assign off = cpu.addr[offBits:1];
    assign idx = cpu.addr[offBits+idxBits:offBits+1];
    assign tag = cpu.addr[15:offBits+idxBits+1];

    assign hit     = validArr[idx] && (tagArr[idx] == tag);
    assign addrErr = cpu.addr >= memLimit;     // never filled

    // control FSM
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            state    <= fetchPkg::idle;
            ackQ     <= 1'b0;
            fillReqQ <= 1'b0;
            validArr <= '0;     // cache starts empty
        end else begin
            case (state)
                fetchPkg::idle: begin
                    // both links must be back at rest first
                    if (cpu.req && !ackQ && !fill.ack) begin
                        state <= fetchPkg::lookup;
                    end
                end
                fetchPkg::lookup: begin
                    if (addrErr || hit) begin
                        ackQ  <= 1'b1;          // hit or error, answer now
                        state <= fetchPkg::respond;
                    end else begin
                        fillReqQ <= 1'b1;       // miss
                        state    <= fetchPkg::fill;
                    end
                end
                fetchPkg::fill: begin
                    if (fill.ack) begin
                        fillReqQ      <= 1'b0;
                        validArr[idx] <= 1'b1;
                        ackQ          <= 1'b1;
                        state         <= fetchPkg::respond;
                    end
                end
                fetchPkg::respond: begin
                    if (!cpu.req) begin
                        ackQ  <= 1'b0;          // phase 4
                        state <= fetchPkg::idle;
                    end
                end
                default: begin
                    state <= fetchPkg::idle;
                end
            endcase
        end
    end

    // line, tag and response data
    always_ff @(posedge clk) begin
        if (state == fetchPkg::lookup) begin
            // junk on a miss, overwritten when the line lands
            dataQ <= addrErr ? '0 : dataArr[idx][off];
        end
        if (state == fetchPkg::fill && fill.ack) begin
            dataArr[idx] <= fill.lineData;
            tagArr[idx]  <= tag;
            dataQ        <= fill.lineData[off];   // bypass into response
        end
    end

    assign cpu.ack  = ackQ;
    assign cpu.data = dataQ;
    assign cpu.err  = addrErr;

    assign fill.req      = fillReqQ;
    assign fill.lineAddr = {cpu.addr[15:offBits+1], {(offBits + 1){1'b0}}};

endmodule

//--- program.hex
// test program image, one 16-bit instruction word per line
// line n holds the word at byte address 2*n
3a41
1c05
7e12
0f9d
5b60
22c7
6d3e
4418
91a2
0b7f
c356
2e04
8fd1
7340
e129
56bb

//--- verif/fetchUnit_properties.sv
`timescale 1ns/1ps
//************************************************************
// fetch unit protocol checks
// four-phase handshakes, cache and memory timing, reset values
//************************************************************
module fetchUnit_properties #(
    parameter int fillLatency = 4    // backing memory wait
) (
    input logic                clk,
    input logic                rstN,
    input logic                reqLink,    // stage -> cache req
    input logic                ackLink,
    input logic                fillReq,    // cache -> memory req
    input logic                fillAck,
    input logic                validIns,
    input fetchPkg::word       pcOut,
    input fetchPkg::cacheState cacheSt
);

    int failCount = 0;   // polled by the testbench top

    reqHeld: assert property (@(posedge clk) disable iff (!rstN)
        reqLink && !ackLink |=> reqLink)
        else begin failCount++; $error("fetch req dropped before ack"); end

    reqRest: assert property (@(posedge clk) disable iff (!rstN)
        $rose(reqLink) |-> !ackLink)
        else begin failCount++; $error("fetch req raised while ack still high"); end

    ackHeld: assert property (@(posedge clk) disable iff (!rstN)
        ackLink && reqLink |=> ackLink)
        else begin failCount++; $error("cache ack dropped while req high"); end

    ackRelease: assert property (@(posedge clk) disable iff (!rstN)
        ackLink && !reqLink |=> !ackLink)
        else begin failCount++; $error("cache ack kept after req fell"); end

    // fill link follows the same four phases
    fillHeld: assert property (@(posedge clk) disable iff (!rstN)
        fillReq && !fillAck |=> fillReq)
        else begin failCount++; $error("fill req dropped before ack"); end

    fillAckHeld: assert property (@(posedge clk) disable iff (!rstN)
        fillAck && fillReq |=> fillAck)
        else begin failCount++; $error("fill ack dropped while req high"); end

    validPulse: assert property (@(posedge clk) disable iff (!rstN)
        validIns |=> !validIns)
        else begin failCount++; $error("validIns high for more than one cycle"); end

    // new fetch req is in lookup on the next cycle
    lookupEntry: assert property (@(posedge clk) disable iff (!rstN)
        $rose(reqLink) |=> cacheSt == fetchPkg::lookup)
        else begin failCount++; $error("cache did not take up the fetch req"); end

    // memory answers fillLatency cycles after the fill req rose
    fillTiming: assert property (@(posedge clk) disable iff (!rstN)
        $rose(fillAck) |-> $past(fillReq, fillLatency) && !$past(fillReq, fillLatency + 1))
        else begin failCount++; $error("fill ack not fillLatency cycles after fill req"); end

    // hit one cycle after lookup, miss one cycle after the fill ack
    ackTiming: assert property (@(posedge clk) disable iff (!rstN)
        $rose(ackLink) |-> $past(fillAck) || ($past(reqLink, 2) && !$past(reqLink, 3)))
        else begin failCount++; $error("cache ack rose at the wrong cycle"); end

    // values right after reset
    resetVals: assert property (@(posedge clk)
        !rstN |=> !validIns && pcOut == '0 && !reqLink)
        else begin failCount++; $error("fetch outputs not cleared by reset"); end

endmodule

bind fetchUnit fetchUnit_properties #(.fillLatency(fillLatency)) props (
    .clk      (clk),
    .rstN     (rstN),
    .reqLink  (reqBus.req),
    .ackLink  (reqBus.ack),
    .fillReq  (fillBus.req),
    .fillAck  (fillBus.ack),
    .validIns (validIns),
    .pcOut    (pcOut),
    .cacheSt  (iCache.state)
);

//--- verif/tbClockGen.sv
`timescale 1ns/1ps
//************************************************************
// testbench clock and reset
//************************************************************
module tbClockGen #(
    parameter int period      = 100,   // ns
    parameter int resetCycles = 3
) (
    output logic clk,
    output logic rstN
);

    initial begin
        clk = 1'b0;
        forever #(period / 2) clk = ~clk;
    end

    initial begin
        rstN = 1'b0;
        repeat (resetCycles) @(posedge clk);
        rstN <= 1'b1;   // released on a rising edge
    end

endmodule

//--- verif/tbFetchUnit.sv
`timescale 1ns/1ps
//************************************************************
// fetch unit testbench
// random stalls and redirects, PC model built from the fetch
// rules, program image as instruction reference
//************************************************************
module tbFetchUnit;

    localparam int clkPeriod   = 100;
    localparam int fillLatency = 4;
    localparam int numRandom   = 300;                  // valid instructions in random run
    localparam int numTests    = numRandom + 3;        // plus directed jumps
    localparam int testCycles  = 4 * (fillLatency + 8); // miss plus dropped refetches
    localparam fetchPkg::word progTop  = 16'd20;       // random flow stays in program.hex
    localparam fetchPkg::word memLimit = 16'(fetchPkg::memWords * 2);

    logic          clk, rstN;
    logic          writePc1, writePc2, branchTake, jump;
    logic          validIns, err;
    fetchPkg::word brAddr, jumpAddr, pcOut, nxtPc, instr;

    fetchPkg::word refMem [fetchPkg::memWords];
    logic [31:0]   rngState;
    fetchPkg::word expPc;       // pcOut of the next valid instruction
    string         expKind;     // rule that set expPc
    logic          redirOut;    // redirect issued, no clean valid since
    logic          randomMode;
    logic          dirReq;      // directed jump waiting to go out
    fetchPkg::word dirAddr;
    int            validCount;

    tbClockGen #(.period(clkPeriod), .resetCycles(3)) clkGen (.clk(clk), .rstN(rstN));

    fetchUnit #(.numLines(8), .fillLatency(fillLatency)) i_dut (
        .clk(clk), .rstN(rstN), .writePc1(writePc1), .writePc2(writePc2),
        .branchTake(branchTake), .jump(jump), .brAddr(brAddr), .jumpAddr(jumpAddr),
        .pcOut(pcOut), .nxtPc(nxtPc), .instr(instr), .validIns(validIns), .err(err)
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic failAndStop();
        $display("** FAIL **");
        $fatal(1, "run stopped at first failure");
    endtask

    task automatic checkValue(input string name, input fetchPkg::word expected,
                              input fetchPkg::word actual);
        assert (actual === expected) else begin
            $display("Error %s: expected %h, actual %h", name, expected, actual);
            failAndStop();
        end
    endtask

    task automatic jumpAndWait(input fetchPkg::word target);
        dirAddr <= target;
        dirReq  <= 1'b1;
        do @(posedge clk); while (dirReq);  // jump has gone out
        do @(posedge clk); while (!(validIns && pcOut == target));
    endtask

    // sample the cycle that just ended, then drive the next one
    always @(posedge clk) begin
        logic          redirect;
        fetchPkg::word target;
        logic [31:0]   r;
        redirect = jump | branchTake;
        target   = jump ? jumpAddr : brAddr;   // jump wins
        rngState = xorshift32(rngState);
        r        = rngState;
        writePc1   <= randomMode ? (r[1:0] != 2'b00) : 1'b1;  // stall one cycle in four
        writePc2   <= randomMode ? (r[3:2] != 2'b00) : 1'b1;
        branchTake <= 1'b0;
        jump       <= 1'b0;
        if (rstN) begin
            checkValue("error flag", 16'((pcOut == 16'hFFFE) || (pcOut >= memLimit)), 16'(err));
            if (validIns) begin
                if (pcOut < memLimit) begin
                    checkValue("instruction content", refMem[pcOut[8:1]], instr);
                end
                checkValue("next pc", pcOut + 16'd2, nxtPc);
                checkValue(expKind, expPc, pcOut);
                validCount++;
                if (redirect) begin
                    expPc   = target;
                    expKind = jump ? "jump at done" : "branch at done";
                end else begin
                    redirOut = 1'b0;
                    expPc    = (writePc1 && writePc2) ? pcOut + 16'd2 : pcOut;
                    expKind  = (writePc1 && writePc2) ? "sequential advance" : "stall hold";
                end
            end else if (redirect) begin
                expPc   = target;      // stale fetch must be dropped
                expKind = jump ? "jump before done" : "branch before done";
            end
            if (!redirOut && dirReq) begin
                jump     <= 1'b1;
                jumpAddr <= dirAddr;
                dirReq   <= 1'b0;
                redirOut = 1'b1;
            end else if (!redirOut && (pcOut >= progTop || (randomMode && r[7:4] == 4'd0))) begin
                jump       <= r[8];
                branchTake <= ~r[8] | r[9];   // both high tests priority
                jumpAddr   <= 16'((r[19:16] % 12) * 2);
                brAddr     <= 16'((r[23:20] % 12) * 2);
                redirOut = 1'b1;
            end
        end
    end

    // property failures from the bound checker
    always @(posedge clk) begin
        if (i_dut.props.failCount != 0) begin
            $display("a protocol assertion inside the fetch unit failed");
            failAndStop();
        end
    end

    initial begin
        #(numTests * testCycles * clkPeriod);
        $display("Timeout: fewer than %0d valid instructions delivered", numTests);
        failAndStop();
    end

    initial begin
        writePc1   <= 1'b1;
        writePc2   <= 1'b1;
        branchTake <= 1'b0;
        jump       <= 1'b0;
        brAddr     <= '0;
        jumpAddr   <= '0;
        randomMode <= 1'b0;
        dirReq     <= 1'b0;
        dirAddr    <= '0;
        rngState   = 32'h802e_f6f9;
        expPc      = '0;
        expKind    = "first fetch after reset";
        redirOut   = 1'b0;
        validCount = 0;
        $readmemh("program.hex", refMem);
        @(posedge rstN);
        @(posedge clk);
        checkValue("reset pc", 16'h0000, pcOut);
        checkValue("reset validIns", 16'h0000, 16'(validIns));
        randomMode <= 1'b1;
        wait (validCount >= numRandom);
        randomMode <= 1'b0;
        jumpAndWait(16'hFFFE);   // increment overflow
        jumpAndWait(memLimit);   // beyond program memory
        jumpAndWait(16'h0008);   // back into cached lines
        @(posedge clk);
        if (i_dut.props.failCount == 0) begin
            $display("** PASS **");
            $finish;
        end else begin
            failAndStop();
        end
    end

endmodule
